/* src/cpu_pkg.sv */
/* Widths, instruction fields, encodings and stage records shared by the
   single-issue CPU pipeline; every RTL module imports it */
`default_nettype none

package cpu_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // Widths and register file geometry
  ////////////////////////////////////////////////////////////////////////////
  localparam int xlen      = 32;  // Data path
  localparam int ilen      = 32;  // Instruction word
  localparam int reg_count = 32;
  localparam int reg_idx_w = 5;
  localparam logic [reg_idx_w-1:0] zero_reg = 5'd31;  // Always reads as zero

  // Instruction field positions
  localparam int op_hi      = 31;
  localparam int op_lo      = 26;
  localparam int ra_hi      = 25;
  localparam int ra_lo      = 21;
  localparam int rb_hi      = 20;
  localparam int rb_lo      = 16;
  localparam int lit_hi     = 20;  // 8-bit literal, zero-extended
  localparam int lit_lo     = 13;
  localparam int lit_flag   = 12;  // Selects literal over rb
  localparam int rc_hi      = 4;
  localparam int rc_lo      = 0;
  localparam int disp_hi    = 20;  // Branch displacement in words
  localparam int disp_lo    = 0;

  ////////////////////////////////////////////////////////////////////////////
  // Encodings
  ////////////////////////////////////////////////////////////////////////////
  typedef enum logic [5:0] {
    op_halt  = 6'h00,
    op_add   = 6'h10,
    op_sub   = 6'h11,
    op_and   = 6'h12,
    op_or    = 6'h13,
    op_xor   = 6'h14,
    op_sll   = 6'h15,
    op_srl   = 6'h16,
    op_cmpeq = 6'h17,
    op_cmplt = 6'h18,  // Signed
    op_br    = 6'h30,  // Links npc into ra
    op_beq   = 6'h39,  // Taken when ra is zero
    op_bne   = 6'h3d   // Taken when ra is nonzero
  } opcode_t;

  typedef enum logic [3:0] {
    alu_add, alu_sub, alu_and, alu_or, alu_xor,
    alu_sll, alu_srl, alu_cmpeq, alu_cmplt
  } alu_func_t;

  typedef enum logic [1:0] {
    br_none, br_uncond, br_if_zero, br_if_nonzero
  } branch_kind_t;

  typedef enum logic [1:0] {
    no_error, halted_on_halt, halted_on_illegal
  } error_status_t;

  ////////////////////////////////////////////////////////////////////////////
  // Stage records
  ////////////////////////////////////////////////////////////////////////////
  typedef struct packed {
    logic            valid;
    logic [xlen-1:0] npc;
    logic [ilen-1:0] ir;
  } fetch_t;  // IF/ID

  typedef struct packed {
    logic                 valid;
    logic [xlen-1:0]      npc;
    logic [xlen-1:0]      opa;      // ra value
    logic [xlen-1:0]      opb;      // rb value
    logic                 use_lit;
    logic [xlen-1:0]      lit;
    logic [xlen-1:0]      disp;     // Sign-extended, still in words
    alu_func_t            alu_func;
    branch_kind_t         branch_kind;
    logic [reg_idx_w-1:0] dest;
    logic                 wr_reg;
    logic                 halt;
    logic                 illegal;
  } decoded_t;  // ID/EX

  typedef struct packed {
    logic                 valid;
    logic                 wr_en;
    logic [reg_idx_w-1:0] wr_idx;
    logic [xlen-1:0]      wr_data;
    logic [xlen-1:0]      npc;
    logic                 halt;
    logic                 illegal;
    logic                 redirect;  // Branch taken
    logic [xlen-1:0]      target;
  } commit_t;  // EX/WB

endpackage

`default_nettype wire

/* src/reg_file.sv */
/* Register file: two combinational read ports, one write port fed by the
   commit record; register 31 reads as zero */
`timescale 1ns/10ps
`default_nettype none

module reg_file import cpu_pkg::*;
(
  input  logic                 clock,
  input  logic                 reset,
  input  logic [reg_idx_w-1:0] rd_idx_a,
  input  logic [reg_idx_w-1:0] rd_idx_b,
  output logic [xlen-1:0]      rd_data_a,
  output logic [xlen-1:0]      rd_data_b,
  input  commit_t              commit
);

  logic [xlen-1:0] regs [reg_count];

  // Reads, zero register forced
  assign rd_data_a = (rd_idx_a == zero_reg) ? '0 : regs[rd_idx_a];
  assign rd_data_b = (rd_idx_b == zero_reg) ? '0 : regs[rd_idx_b];

  always_ff @(posedge clock)
  begin
    if (reset)
    begin
      for (int i = 0; i < reg_count; i++)
        regs[i] <= '0;
    end
    else if (commit.valid && commit.wr_en)
      regs[commit.wr_idx] <= commit.wr_data;  // Writeback
  end

  // Execute must already have dropped writes to the zero register
  a_no_zero_write: assert property (@(posedge clock) disable iff (reset)
    commit.valid && commit.wr_en |-> commit.wr_idx != zero_reg);

endmodule

`default_nettype wire

/* src/fetch_unit.sv */
/* Instruction fetch: holds the PC, raises the instruction port request and
   captures the returned word into the IF/ID register */
`timescale 1ns/10ps
`default_nettype none

module fetch_unit import cpu_pkg::*;
(
  input  logic            clock,
  input  logic            reset,
  input  logic            fetch_start,  // One-cycle kick from control
  input  logic [xlen-1:0] next_pc,
  output logic            imem_req,     // Level, held until imem_valid
  output logic [xlen-1:0] imem_addr,
  input  logic            imem_valid,
  input  logic [ilen-1:0] imem_data,
  output fetch_t          fetch
);

  logic [xlen-1:0] pc;
  logic            capture;  // Word arrives this edge

  assign capture   = imem_req && imem_valid;
  assign imem_addr = pc;

  // PC and request level
  always_ff @(posedge clock)
  begin
    if (reset)
    begin
      pc       <= '0;
      imem_req <= 1'b0;
    end
    else if (fetch_start)
    begin
      pc       <= next_pc;
      imem_req <= 1'b1;
    end
    else if (capture)
      imem_req <= 1'b0;  // Drops on the valid edge
  end

  ////////////////////////////////////////////////////////////////////////////
  // IF/ID register
  ////////////////////////////////////////////////////////////////////////////
  always_ff @(posedge clock)
  begin
    if (reset)
      fetch.valid <= 1'b0;
    else
      fetch.valid <= capture;  // One-cycle pulse
    if (capture)
    begin
      fetch.npc <= pc + xlen'(4);
      fetch.ir  <= imem_data;
    end
  end

  // Address must not move while memory is still working on it
  a_addr_stable: assert property (@(posedge clock) disable iff (reset)
    imem_req && !imem_valid |=> $stable(imem_addr));

  // Control only restarts fetch once the previous request has finished
  a_start_idle: assert property (@(posedge clock) disable iff (reset)
    fetch_start |-> !imem_req);

endmodule

`default_nettype wire

/* src/decode_unit.sv */
/* Instruction decode: splits fields, requests both operands from the
   register file and registers the ID/EX stage */
`timescale 1ns/10ps
`default_nettype none

module decode_unit import cpu_pkg::*;
(
  input  logic                 clock,
  input  logic                 reset,
  input  fetch_t               fetch,
  output logic [reg_idx_w-1:0] rd_idx_a,
  output logic [reg_idx_w-1:0] rd_idx_b,
  input  logic [xlen-1:0]      rd_data_a,
  input  logic [xlen-1:0]      rd_data_b,
  output decoded_t             decoded
);

  logic [ilen-1:0]      ir;
  opcode_t              opcode;
  logic [reg_idx_w-1:0] ra;
  logic [reg_idx_w-1:0] rc;
  alu_func_t            alu_func;
  branch_kind_t         branch_kind;
  logic [reg_idx_w-1:0] dest;
  logic                 wr_reg;
  logic                 halt;
  logic                 illegal;
  decoded_t             nxt;

  // Field split
  assign ir       = fetch.ir;
  assign opcode   = opcode_t'(ir[op_hi:op_lo]);
  assign ra       = ir[ra_hi:ra_lo];
  assign rc       = ir[rc_hi:rc_lo];
  assign rd_idx_a = ra;                // Also the branch test register
  assign rd_idx_b = ir[rb_hi:rb_lo];

  ////////////////////////////////////////////////////////////////////////////
  // Opcode map
  ////////////////////////////////////////////////////////////////////////////
  always_comb
  begin
    alu_func    = alu_add;
    branch_kind = br_none;
    dest        = rc;     // ALU ops write rc
    wr_reg      = 1'b1;
    halt        = 1'b0;
    illegal     = 1'b0;
    case (opcode)
      op_add:   alu_func = alu_add;
      op_sub:   alu_func = alu_sub;
      op_and:   alu_func = alu_and;
      op_or:    alu_func = alu_or;
      op_xor:   alu_func = alu_xor;
      op_sll:   alu_func = alu_sll;
      op_srl:   alu_func = alu_srl;
      op_cmpeq: alu_func = alu_cmpeq;
      op_cmplt: alu_func = alu_cmplt;
      op_br:
      begin
        branch_kind = br_uncond;
        dest        = ra;  // Link register
      end
      op_beq:
      begin
        branch_kind = br_if_zero;
        wr_reg      = 1'b0;
      end
      op_bne:
      begin
        branch_kind = br_if_nonzero;
        wr_reg      = 1'b0;
      end
      op_halt:
      begin
        wr_reg = 1'b0;
        halt   = 1'b1;
      end
      default:
      begin
        wr_reg  = 1'b0;  // Undefined opcode
        illegal = 1'b1;
      end
    endcase
  end

  // Next ID/EX contents
  always_comb
  begin
    nxt.valid       = fetch.valid;
    nxt.npc         = fetch.npc;
    nxt.opa         = rd_data_a;
    nxt.opb         = rd_data_b;
    nxt.use_lit     = ir[lit_flag];
    nxt.lit         = xlen'(ir[lit_hi:lit_lo]);
    nxt.disp        = {{(xlen-disp_hi-1){ir[disp_hi]}}, ir[disp_hi:disp_lo]};
    nxt.alu_func    = alu_func;
    nxt.branch_kind = branch_kind;
    nxt.dest        = dest;
    nxt.wr_reg      = wr_reg;
    nxt.halt        = halt;
    nxt.illegal     = illegal;
  end

  // ID/EX register, only valid is cleared
  always_ff @(posedge clock)
  begin
    decoded <= nxt;
    if (reset)
      decoded.valid <= 1'b0;
  end

endmodule

`default_nettype wire

/* src/execute_unit.sv */
/* Execute stage: operand select, ALU, branch decision and target, then the
   EX/WB register that forms the commit record */
`timescale 1ns/10ps
`default_nettype none

module execute_unit import cpu_pkg::*;
(
  input  logic     clock,
  input  logic     reset,
  input  decoded_t decoded,
  output commit_t  commit
);

  localparam int shamt_w = $clog2(xlen);

  logic [xlen-1:0]    opb;
  logic [shamt_w-1:0] shamt;
  logic [xlen-1:0]    alu_out;
  logic               taken;
  commit_t            nxt;

  assign opb   = decoded.use_lit ? decoded.lit : decoded.opb;
  assign shamt = opb[shamt_w-1:0];  // Low 5 bits only

  ////////////////////////////////////////////////////////////////////////////
  // ALU
  ////////////////////////////////////////////////////////////////////////////
  always_comb
  begin
    case (decoded.alu_func)
      alu_add:   alu_out = decoded.opa + opb;
      alu_sub:   alu_out = decoded.opa - opb;
      alu_and:   alu_out = decoded.opa & opb;
      alu_or:    alu_out = decoded.opa | opb;
      alu_xor:   alu_out = decoded.opa ^ opb;
      alu_sll:   alu_out = decoded.opa << shamt;
      alu_srl:   alu_out = decoded.opa >> shamt;  // Logical
      alu_cmpeq: alu_out = xlen'(decoded.opa == opb);
      alu_cmplt: alu_out = xlen'($signed(decoded.opa) < $signed(opb));
      default:   alu_out = '0;
    endcase
  end

  // Branch decision on ra
  always_comb
  begin
    case (decoded.branch_kind)
      br_uncond:     taken = 1'b1;
      br_if_zero:    taken = (decoded.opa == '0);
      br_if_nonzero: taken = (decoded.opa != '0);
      default:       taken = 1'b0;
    endcase
  end

  ////////////////////////////////////////////////////////////////////////////
  // Commit record
  ////////////////////////////////////////////////////////////////////////////
  always_comb
  begin
    nxt.valid    = decoded.valid;
    nxt.wr_en    = decoded.valid && decoded.wr_reg && (decoded.dest != zero_reg);
    nxt.wr_idx   = decoded.dest;
    // Link write carries the return address
    nxt.wr_data  = (decoded.branch_kind == br_uncond) ? decoded.npc : alu_out;
    nxt.npc      = decoded.npc;
    nxt.halt     = decoded.valid && decoded.halt;
    nxt.illegal  = decoded.valid && decoded.illegal;
    nxt.redirect = decoded.valid && taken;
    nxt.target   = decoded.npc + (decoded.disp << 2);  // Words to bytes
  end

  // EX/WB register, control flags cleared
  always_ff @(posedge clock)
  begin
    commit <= nxt;
    if (reset)
    begin
      commit.valid    <= 1'b0;
      commit.wr_en    <= 1'b0;
      commit.halt     <= 1'b0;
      commit.illegal  <= 1'b0;
      commit.redirect <= 1'b0;
    end
  end

endmodule

`default_nettype wire

/* src/pipe_control.sv */
/* Pipeline sequencing that keeps one instruction in flight, launches the next
   fetch from each commit and holds the sticky halt or illegal status */
`timescale 1ns/10ps
`default_nettype none

module pipe_control import cpu_pkg::*;
(
  input  logic            clock,
  input  logic            reset,
  input  commit_t         commit,
  output logic            fetch_start,  // One-cycle pulse
  output logic [xlen-1:0] next_pc,
  output error_status_t   status
);

  logic started;  // First fetch issued since reset
  logic halted;   // Sticky until reset
  logic stop;     // Commit ends the program

  assign stop = commit.halt || commit.illegal;

  ////////////////////////////////////////////////////////////////////////////
  // Sequencing and status
  ////////////////////////////////////////////////////////////////////////////
  always_ff @(posedge clock)
  begin
    if (reset)
    begin
      started     <= 1'b0;
      halted      <= 1'b0;
      fetch_start <= 1'b0;
      status      <= no_error;
    end
    else
    begin
      fetch_start <= 1'b0;
      if (!started)
      begin
        started     <= 1'b1;
        fetch_start <= 1'b1;  // Boot fetch at PC 0
      end
      else if (commit.valid && !halted)
      begin
        if (stop)
        begin
          halted <= 1'b1;
          // Illegal wins over halt
          status <= commit.illegal ? halted_on_illegal : halted_on_halt;
        end
        else
          fetch_start <= 1'b1;
      end
    end
  end

  // Next PC from the retiring instruction
  always_ff @(posedge clock)
  begin
    if (!started)
      next_pc <= '0;
    else if (commit.valid)
      next_pc <= commit.redirect ? commit.target : commit.npc;
  end

  // Once a program has stopped nothing restarts fetch and nothing more retires
  a_no_start_halted: assert property (@(posedge clock) disable iff (reset)
    halted |-> !fetch_start && !commit.valid);

endmodule

`default_nettype wire

/* src/cpu_pipeline.sv */
/* Top level of the four-stage CPU pipeline; connects control, fetch,
   decode, register file and execute around the instruction port */
`timescale 1ns/10ps
`default_nettype none

module cpu_pipeline import cpu_pkg::*;
(
  input  logic            clock,
  input  logic            reset,
  output logic            imem_req,
  output logic [xlen-1:0] imem_addr,
  input  logic            imem_valid,
  input  logic [ilen-1:0] imem_data,
  output commit_t         commit,   // Retired instruction
  output error_status_t   status
);

  logic                 fetch_start;
  logic [xlen-1:0]      next_pc;
  fetch_t               fetch;
  decoded_t             decoded;
  logic [reg_idx_w-1:0] rd_idx_a;
  logic [reg_idx_w-1:0] rd_idx_b;
  logic [xlen-1:0]      rd_data_a;
  logic [xlen-1:0]      rd_data_b;

  ////////////////////////////////////////////////////////////////////////////
  // Control
  ////////////////////////////////////////////////////////////////////////////
  pipe_control i_control (
    .clock       (clock),
    .reset       (reset),
    .commit      (commit),
    .fetch_start (fetch_start),
    .next_pc     (next_pc),
    .status      (status)
  );

  ////////////////////////////////////////////////////////////////////////////
  // Datapath, IF to WB
  ////////////////////////////////////////////////////////////////////////////
  fetch_unit i_fetch (
    .clock       (clock),
    .reset       (reset),
    .fetch_start (fetch_start),
    .next_pc     (next_pc),
    .imem_req    (imem_req),
    .imem_addr   (imem_addr),
    .imem_valid  (imem_valid),
    .imem_data   (imem_data),
    .fetch       (fetch)
  );

  decode_unit i_decode (
    .clock     (clock),
    .reset     (reset),
    .fetch     (fetch),
    .rd_idx_a  (rd_idx_a),
    .rd_idx_b  (rd_idx_b),
    .rd_data_a (rd_data_a),
    .rd_data_b (rd_data_b),
    .decoded   (decoded)
  );

  reg_file i_regs (
    .clock     (clock),
    .reset     (reset),
    .rd_idx_a  (rd_idx_a),
    .rd_idx_b  (rd_idx_b),
    .rd_data_a (rd_data_a),
    .rd_data_b (rd_data_b),
    .commit    (commit)     // WB write port
  );

  execute_unit i_execute (
    .clock   (clock),
    .reset   (reset),
    .decoded (decoded),
    .commit  (commit)
  );

endmodule

`default_nettype wire

/* testbench/tb_clock_gen.sv */
/* Clock and reset source for the CPU pipeline testbench; reset is held for
   4 cycles at start and again each time restart is sampled high */
`timescale 1ns/10ps
`default_nettype none

module tb_clock_gen
(
  output logic clock,
  output logic reset,
  input  logic restart  // Sampled on the rising edge
);

  int hold;  // Reset edges still to come

  initial
  begin
    clock = 1'b0;
    reset = 1'b1;
    hold  = 3;  // Plus the first edge makes 4
  end

  always #5 clock = ~clock;  // 10 ns period

  always @(posedge clock)
  begin
    if (restart)
      hold = 4;
    #1;
    if (hold > 0)
    begin
      reset = 1'b1;
      hold  = hold - 1;
    end
    else
      reset = 1'b0;
  end

endmodule

`default_nettype wire

/* testbench/tb_cpu_pipeline.sv */
/* Testbench for the CPU pipeline that runs each program of the vectors file
   against a random-latency instruction memory and checks every commit */
`timescale 1ns/10ps
`default_nettype none

module tb_cpu_pipeline import cpu_pkg::*;
();

  typedef struct packed {
    logic [7:0]  sec;
    logic [31:0] addr;
    logic [31:0] word;
  } prog_entry_t;

  typedef struct packed {
    logic [7:0]  sec;
    logic        valid;
    logic        wr_en;
    logic [4:0]  wr_idx;
    logic [31:0] wr_data;
    logic [31:0] npc;
  } exp_commit_t;

  logic            clock;
  logic            reset;
  logic            restart;
  logic            imem_req;
  logic [xlen-1:0] imem_addr;
  logic            imem_valid;
  logic [ilen-1:0] imem_data;
  commit_t         commit;
  error_status_t   status;

  logic [31:0] imem [256];    // Word-addressed program memory
  prog_entry_t prog[$];
  exp_commit_t expected[$];
  logic [1:0]  final_status[$];
  int          sec_count;
  int          cycles = 0;
  int          limit = 100;   // Replaced once the vectors are loaded
  int          fetches;       // Words handed to the DUT this section
  int          wait_left;     // Extra cycles before imem_valid
  logic        mem_busy;
  logic        mem_reset;
  logic [31:0] lfsr;

  tb_clock_gen i_clock_gen (
    .clock   (clock),
    .reset   (reset),
    .restart (restart)
  );

  cpu_pipeline i_dut (
    .clock      (clock),
    .reset      (reset),
    .imem_req   (imem_req),
    .imem_addr  (imem_addr),
    .imem_valid (imem_valid),
    .imem_data  (imem_data),
    .commit     (commit),
    .status     (status)
  );

  ////////////////////////////////////////////////////////////////////////////
  // Failure reporting and random bits
  ////////////////////////////////////////////////////////////////////////////
  task automatic abort_run();
    $display("Test failed");
    $fatal(1, "simulation aborted");
  endtask

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    assert (got === exp)
    else
    begin
      $display("ERROR at %0t ns: %s is %h, expected %h", $time, name, got, exp);
      abort_run();
    end
  endtask

  task automatic check_true(input logic cond, input string what);
    assert (cond)
    else
    begin
      $display("ERROR at %0t ns: %s", $time, what);
      abort_run();
    end
  endtask

  // x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  task automatic draw_latency(output int d);
    lfsr = lfsr_next(lfsr);
    d    = lfsr[0];
    lfsr = lfsr_next(lfsr);
    d    = d * 2 + lfsr[0];  // 0 to 3
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Instruction memory model
  ////////////////////////////////////////////////////////////////////////////
  always @(posedge clock)
  begin
    mem_reset = reset;
    #1;
    if (mem_reset)
    begin
      imem_valid = 1'b0;
      mem_busy   = 1'b0;
    end
    else if (imem_valid)
    begin
      imem_valid = 1'b0;  // Word taken at this edge
      mem_busy   = 1'b0;
      fetches    = fetches + 1;
    end
    else if (imem_req)
    begin
      if (!mem_busy)
      begin
        check_true(imem_addr[31:10] == '0 && imem_addr[1:0] == 2'b00,
                   "fetch address outside program memory");
        mem_busy = 1'b1;
        draw_latency(wait_left);
      end
      else
        wait_left = wait_left - 1;
      if (wait_left == 0)
      begin
        imem_valid = 1'b1;
        imem_data  = imem[imem_addr[9:2]];
      end
    end
  end

  // Run limit
  always @(posedge clock)
  begin
    cycles = cycles + 1;
    check_true(cycles < limit, $sformatf("no end of run within %0d cycles", limit));
  end

  ////////////////////////////////////////////////////////////////////////////
  // Vectors
  ////////////////////////////////////////////////////////////////////////////
  task automatic load_vectors();
    int          fd;
    int          got;
    int          sec;
    string       line;
    byte         tag;
    logic [31:0] f1, f2, f3, f4, f5;
    prog_entry_t pe;
    exp_commit_t ce;
    sec       = -1;
    sec_count = 0;
    fd = $fopen("testbench/cpu_vectors.txt", "r");
    check_true(fd != 0, "cannot open testbench/cpu_vectors.txt");
    while (!$feof(fd))
    begin
      got = $fgets(line, fd);
      tag = (got > 0) ? line.getc(0) : "#";
      case (tag)
        "#", "\n", "\r", " ": ;  // Comments and blank lines
        "R":
        begin
          sec       = sec_count;
          sec_count = sec_count + 1;
        end
        "P":
        begin
          got = $sscanf(line, "P %h %h", f1, f2);
          check_true(got == 2 && sec >= 0 && f1 < 1024 && f1[1:0] == 2'b00,
                     "bad program line in vectors file");
          pe.sec  = 8'(sec);
          pe.addr = f1;
          pe.word = f2;
          prog.push_back(pe);
        end
        "C":
        begin
          got = $sscanf(line, "C %h %h %h %h %h", f1, f2, f3, f4, f5);
          check_true(got == 5 && sec >= 0, "bad commit line in vectors file");
          ce.sec     = 8'(sec);
          ce.valid   = f1[0];
          ce.wr_en   = f2[0];
          ce.wr_idx  = f3[4:0];
          ce.wr_data = f4;
          ce.npc     = f5;
          expected.push_back(ce);
        end
        "S":
        begin
          got = $sscanf(line, "S %h", f1);
          check_true(got == 1 && final_status.size() == sec,
                     "bad status line in vectors file");
          final_status.push_back(f1[1:0]);
        end
        default: check_true(1'b0, "unrecognized line in vectors file");
      endcase
    end
    $fclose(fd);
    check_true(sec_count > 0 && final_status.size() == sec_count,
               "vectors file has a section without a final status");
  endtask

  task automatic load_program(input int sec);
    for (int i = 0; i < 256; i++)
      imem[i] = {6'h3f, 26'(i)};  // Undefined opcode tagged with its index
    foreach (prog[i])
      if (prog[i].sec == sec)
        imem[prog[i].addr[9:2]] = prog[i].word;
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Section runner
  ////////////////////////////////////////////////////////////////////////////
  task automatic wait_for_commit();
    do
    begin
      @(posedge clock);
      #1;
      check_true(status == no_error, "program stopped before all its commits arrived");
    end
    while (!commit.valid);
  endtask

  task automatic run_section(input int sec);
    int          first;
    int          count;
    int          last;
    logic [31:0] next_npc;
    logic        jump;
    exp_commit_t exp;
    first = 0;
    count = 0;
    foreach (expected[i])
      if (expected[i].sec == sec)
      begin
        if (count == 0)
          first = i;
        count++;
      end
    check_true(count > 0, "section without expected commits");
    last = first + count - 1;
    load_program(sec);
    if (sec > 0)
    begin
      restart = 1'b1;  // Already 1 ns past an edge
      @(posedge clock);
      #1;
      restart = 1'b0;
    end
    do
      @(posedge clock);
    while (reset);
    #1;
    fetches = 0;
    check_value("status", status, no_error);  // Cleared by reset
    check_value("imem_req", imem_req, 1'b0);
    check_value("commit.valid", commit.valid, 1'b0);

    for (int i = first; i <= last; i++)
    begin
      exp = expected[i];
      wait_for_commit();
      check_value("commit.valid", commit.valid, exp.valid);
      check_value("commit.wr_en", commit.wr_en, exp.wr_en);
      if (exp.wr_en)
      begin
        check_value("commit.wr_idx", commit.wr_idx, exp.wr_idx);
        check_value("commit.wr_data", commit.wr_data, exp.wr_data);
      end
      check_value("commit.npc", commit.npc, exp.npc);
      // Stop flags only on the last commit of the program
      check_value("commit.halt", commit.halt,
                  i == last && final_status[sec] == halted_on_halt);
      check_value("commit.illegal", commit.illegal,
                  i == last && final_status[sec] == halted_on_illegal);
      // A taken branch shows up as a jump in the next npc
      next_npc = (i < last) ? expected[i + 1].npc : exp.npc + 32'd4;
      jump     = (next_npc != exp.npc + 32'd4);
      check_value("commit.redirect", commit.redirect, jump);
      if (jump)
        check_value("commit.target", commit.target, next_npc - 32'd4);
    end

    @(posedge clock);
    #1;
    check_value("status", status, final_status[sec]);  // Latched after the stop
    check_value("fetch count", fetches, count);
    repeat (20)  // Stopped pipeline stays quiet
    begin
      @(posedge clock);
      #1;
      check_true(!imem_req, "instruction request raised after the program stopped");
      check_true(!commit.valid, "commit arrived when none was expected");
      check_value("status", status, final_status[sec]);
    end
  endtask

  initial
  begin
    restart    = 1'b0;
    imem_valid = 1'b0;
    imem_data  = '0;
    mem_busy   = 1'b0;
    wait_left  = 0;
    fetches    = 0;
    lfsr       = 32'hb23c4971;
    load_vectors();
    limit = expected.size() * 12 + 100;
    for (int s = 0; s < sec_count; s++)
      run_section(s);
    $display("Test passed");
    $finish;
  end

endmodule

`default_nettype wire

/* testbench/cpu_vectors.txt */
# R = new section with reset; P addr word = program word; S status = final status
# C valid wr_en wr_idx wr_data npc = expected commit, idx and data unchecked when wr_en is 0
R
P 00000000 43e0b001 add r31,#5 -> r1
P 00000004 43f91002 add r31,#200 -> r2
P 00000008 44220003 sub r1,r2 -> r3
P 0000000c 48620004 and r3,r2 -> r4
P 00000010 4c261005 or r1,#0x30 -> r5
P 00000014 50620006 xor r3,r2 -> r6
P 00000018 54249007 sll r1,#36 -> r7
P 0000001c 58610008 srl r3,r1 -> r8
P 00000020 60610009 cmplt r3,r1 -> r9
P 00000024 5c20b00a cmpeq r1,#5 -> r10
P 00000028 6023000b cmplt r1,r3 -> r11
P 0000002c 4022001f add r1,r2 -> r31
P 00000030 e7e00002 beq r31,+2 taken
P 00000034 00000000 halt, skipped
P 00000038 00000000 halt, skipped
P 0000003c f7e00005 bne r31,+5 not taken
P 00000040 f4200001 bne r1,+1 taken
P 00000044 00000000 halt, skipped
P 00000048 c1a00002 br r13,+2
P 0000004c 00000000 halt, skipped
P 00000050 00000000 halt, skipped
P 00000054 41bf000e add r13,r31 -> r14
P 00000058 e43fffff beq r1,-1 not taken
P 0000005c 44203001 sub r1,#1 -> r1
P 00000060 f43ffffe bne r1,-2 loop
P 00000064 00000000 halt
C 1 1 01 00000005 00000004
C 1 1 02 000000c8 00000008
C 1 1 03 ffffff3d 0000000c
C 1 1 04 00000008 00000010
C 1 1 05 00000035 00000014
C 1 1 06 fffffff5 00000018
C 1 1 07 00000050 0000001c
C 1 1 08 07fffff9 00000020
C 1 1 09 00000001 00000024
C 1 1 0a 00000001 00000028
C 1 1 0b 00000000 0000002c
C 1 0 1f 00000000 00000030
C 1 0 00 00000000 00000034
C 1 0 00 00000000 00000040
C 1 0 00 00000000 00000044
C 1 1 0d 0000004c 0000004c
C 1 1 0e 0000004c 00000058
C 1 0 00 00000000 0000005c
C 1 1 01 00000004 00000060
C 1 0 00 00000000 00000064
C 1 1 01 00000003 00000060
C 1 0 00 00000000 00000064
C 1 1 01 00000002 00000060
C 1 0 00 00000000 00000064
C 1 1 01 00000001 00000060
C 1 0 00 00000000 00000064
C 1 1 01 00000000 00000060
C 1 0 00 00000000 00000064
C 1 0 00 00000000 00000068
S 1
R
P 00000000 43e0f001 add r31,#7 -> r1
P 00000004 403f0002 add r1,r31 -> r2
P 00000008 04000002 undefined opcode 0x01
C 1 1 01 00000007 00000004
C 1 1 02 00000007 00000008
C 1 0 00 00000000 0000000c
S 2

/* all.f */
src/cpu_pkg.sv
src/reg_file.sv
src/fetch_unit.sv
src/decode_unit.sv
src/execute_unit.sv
src/pipe_control.sv
src/cpu_pipeline.sv
testbench/tb_clock_gen.sv
testbench/tb_cpu_pipeline.sv

/* Bender.yml */
package:
  name: cpu_pipeline

sources:
  - src/cpu_pkg.sv
  - src/reg_file.sv
  - src/fetch_unit.sv
  - src/decode_unit.sv
  - src/execute_unit.sv
  - src/pipe_control.sv
  - src/cpu_pipeline.sv
  - target: test
    files:
      - testbench/tb_clock_gen.sv
      - testbench/tb_cpu_pipeline.sv
